// ==== compile.f ====
+incdir+.
msx_pkg.sv
upload_pkg.sv
slot_if.sv
memory_upload.sv
mapper_detect.sv
slot_table.sv
msx_memory_upload.sv
upload_checker.sv
tb_msx_memory_upload.sv

// ==== mapper_detect.sv ====
`timescale 1ns/1ns
`include "upload_consts.svh"

module mapper_detect
   import msx_pkg::*, upload_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        restart,
   input  logic        sample,
   input  conf_byte_t  data,
   input  img_size_t   rom_size,
   output mapper_typ_t mapper
);

   typedef logic [15:0] hit_cnt_t;

   logic  [1:0] phase;         // Bytes of an LD (nn),A seen
   conf_byte_t  addr_lo;
   logic [15:0] wr_addr;
   hit_cnt_t    cnt_konami;
   hit_cnt_t    cnt_scc;
   hit_cnt_t    cnt_ascii8;
   hit_cnt_t    cnt_ascii16;

   assign wr_addr = {data, addr_lo};

   always_ff @(posedge clk) begin
      if (reset || restart) begin
         phase       <= 2'd0;
         cnt_konami  <= '0;
         cnt_scc     <= '0;
         cnt_ascii8  <= '0;
         cnt_ascii16 <= '0;
      end else if (sample) begin
         case (phase)
            2'd0: begin
               if (data == 8'h32)
                  phase <= 2'd1;
            end
            2'd1: begin
               addr_lo <= data;
               phase   <= 2'd2;
            end
            default: begin
               phase <= 2'd0;
               if (wr_addr inside {16'h4000, 16'h6000, 16'h8000, 16'ha000})
                  cnt_konami <= cnt_konami + 1'b1;
               if (wr_addr inside {16'h5000, 16'h7000, 16'h9000, 16'hb000})
                  cnt_scc <= cnt_scc + 1'b1;
               if (wr_addr inside {16'h6800, 16'h7000, 16'h7800})
                  cnt_ascii8 <= cnt_ascii8 + 1'b1;
               if (wr_addr inside {16'h6000, 16'h77ff})
                  cnt_ascii16 <= cnt_ascii16 + 1'b1;
            end
         endcase
      end
   end

   always_comb begin
      hit_cnt_t best;
      best   = '0;
      mapper = mapper_offset;
      if (rom_size > `UPL_DETECT_MIN) begin
         // Later checks win a tie
         if (cnt_konami != '0) begin
            mapper = mapper_konami;
            best   = cnt_konami;
         end
         if (cnt_scc != '0 && cnt_scc >= best) begin
            mapper = mapper_konami_scc;
            best   = cnt_scc;
         end
         if (cnt_ascii8 != '0 && cnt_ascii8 >= best) begin
            mapper = mapper_ascii8;
            best   = cnt_ascii8;
         end
         if (cnt_ascii16 != '0 && cnt_ascii16 >= best)
            mapper = mapper_ascii16;
      end
   end

endmodule

// ==== memory_upload.sv ====
`timescale 1ns/1ns
`include "upload_consts.svh"

module memory_upload
   import msx_pkg::*, upload_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         ioctl_download,
   input  logic         rom_eject,
   input  logic  [15:0] ioctl_index,
   input  img_size_t    ioctl_addr,
   input  conf_byte_t   ddr3_dout,
   input  logic         ddr3_ready,
   input  logic         sdram_ready,
   output logic         reset_rq,
   output logic         ddr3_rd,
   output logic         ddr3_request,
   output logic         ram_ce,
   output logic         sdram_rq,
   output logic         detect_restart,
   output ddr_addr_t    ddr3_addr,
   output ram_addr_t    ram_addr,
   output conf_byte_t   ram_din,
   output lookup_RAM_t  lookup_RAM [`UPL_LOOKUPS],
   output bios_config_t bios_config,
   output img_size_t    rom_size,
   slot_if.seq          slots
);

   typedef enum logic [2:0] {
      st_idle,
      st_clean,
      st_read_conf,
      st_check_conf,
      st_fill_ram,
      st_store_conf
   } state_t;

   img_size_t   conf_size;
   img_size_t   rom_a_size;
   img_size_t   rom_b_size;
   logic        download_last;
   logic        load;

   state_t      state;
   conf_byte_t  conf [`UPL_CONF_BYTES];
   logic  [3:0] head;
   logic  [3:0] ref_ram;
   img_size_t   counter;           // Bytes left minus one
   ddr_addr_t   save_addr;
   conf_byte_t  fill_byte;
   logic        byte_valid;
   logic        rom_copy;
   config_typ_t conf_typ;
   logic        more_conf;
   logic        header_ok;
   logic        skip_rec;
   logic        slot_rec;
   logic        from_ddr;
   logic        ddr_take;

   // Image sizes, index 2 only triggers a reload
   always_ff @(posedge clk) begin
      if (reset) begin
         download_last <= 1'b0;
         load          <= 1'b0;
         conf_size     <= '0;
         rom_a_size    <= '0;
         rom_b_size    <= '0;
      end else begin
         download_last <= ioctl_download;
         load          <= 1'b0;
         if (download_last && !ioctl_download) begin
            case (ioctl_index[5:0])
               6'd1:    conf_size  <= ioctl_addr;
               6'd3:    rom_a_size <= ioctl_addr;
               6'd4:    rom_b_size <= ioctl_addr;
               default: ;
            endcase
            load <= ioctl_index[5:0] inside {6'd1, 6'd2, 6'd3, 6'd4};
         end
         if (rom_eject) begin
            rom_a_size <= '0;
            rom_b_size <= '0;
            load       <= 1'b1;
         end
      end
   end

   assign conf_typ  = config_typ_t'(conf[4]);
   assign more_conf = ddr3_addr < ddr_addr_t'(conf_size);
   assign header_ok = {conf[0], conf[1], conf[2]} == "MSX";
   assign skip_rec  = (conf_typ == config_slot_a && rom_a_size == '0) ||
                      (conf_typ == config_slot_b && rom_b_size == '0);
   assign slot_rec  = conf_typ inside {config_none, config_slot_a, config_slot_b, config_fdc};
   assign from_ddr  = rom_copy || conf[3][6];
   assign ddr_take  = ddr3_rd && ddr3_ready;
   assign reset_rq  = state != st_idle;
   assign rom_size  = rom_a_size;

   // Power-on pattern for plain RAM
   assign ram_din = from_ddr    ? fill_byte :
                    ram_addr[8] ? (ram_addr[1] ? 8'hff : 8'h00) :
                                  (ram_addr[1] ? 8'h00 : 8'hff);

   assign slots.clear   = state == st_clean;
   assign slots.store   = state == st_store_conf && slot_rec;
   assign slots.ref_ram = ref_ram;
   assign slots.mapper  = mapper_typ_t'(conf[3][5:0]);
   assign slots.device  = conf_typ == config_fdc ? device_fdc : device_none;

   for (genvar t = 0; t < 4; t++) begin : g_target
      assign slots.target[t] = slot_target_t'({conf[7 + 2 * t], conf[8 + 2 * t][5:0]});
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= st_idle;
         ddr3_rd        <= 1'b0;
         ddr3_request   <= 1'b0;
         ram_ce         <= 1'b0;
         sdram_rq       <= 1'b0;
         detect_restart <= 1'b0;
         byte_valid     <= 1'b0;
         rom_copy       <= 1'b0;
         head           <= '0;
         ddr3_addr      <= '0;
         ram_addr       <= '0;
         bios_config    <= '0;
         for (int i = 0; i < `UPL_LOOKUPS; i++)
            lookup_RAM[i] <= '0;
      end else begin
         ram_ce         <= 1'b0;
         detect_restart <= 1'b0;
         if (ram_ce)
            ram_addr <= ram_addr + 1'b1;
         if (ddr_take) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end

         case (state)
            st_idle: ddr3_request <= 1'b0;
            st_clean: begin
               ddr3_request <= 1'b1;
               state        <= st_read_conf;
            end
            st_read_conf: begin
               if (ddr_take) begin
                  conf[head] <= ddr3_dout;
                  head       <= head + 1'b1;
                  if (head == 4'(`UPL_CONF_BYTES - 1))
                     state <= st_check_conf;
                  else
                     ddr3_rd <= 1'b1;
               end else if (!ddr3_rd) begin
                  // Start of a record
                  if (more_conf)
                     ddr3_rd <= 1'b1;
                  else
                     state <= st_idle;
               end
            end
            st_check_conf: begin
               state <= st_idle;
               if (header_ok) begin
                  if (skip_rec) begin
                     state <= st_read_conf;     // No image behind it
                  end else if (conf_typ == config_slot_a) begin
                     save_addr           <= ddr3_addr;
                     ddr3_addr           <= `UPL_ROM_A_BASE;
                     rom_copy            <= 1'b1;
                     detect_restart      <= 1'b1;
                     counter             <= rom_a_size - 1'b1;
                     sdram_rq            <= 1'b1;
                     state               <= st_fill_ram;
                     lookup_RAM[ref_ram] <= '{addr: ram_addr,
                                              size: 16'(rom_a_size >> `UPL_PAGE_BITS),
                                              ro:   1'b1};
                  end else if (conf[3][7]) begin
                     counter  <= (img_size_t'({conf[5], conf[6]}) << `UPL_PAGE_BITS) - 1'b1;
                     sdram_rq <= 1'b1;
                     state    <= st_fill_ram;
                     lookup_RAM[ref_ram] <= '{addr: ram_addr,
                                              size: {conf[5], conf[6]},
                                              ro:   conf[3][6]};
                  end else begin
                     state <= st_store_conf;
                  end
               end
            end
            st_fill_ram: begin
               if (ddr_take) begin
                  fill_byte  <= ddr3_dout;
                  byte_valid <= 1'b1;
               end else if (from_ddr && !byte_valid && !ddr3_rd) begin
                  ddr3_rd <= 1'b1;
               end
               if (sdram_ready && !ram_ce && (byte_valid || !from_ddr)) begin
                  ram_ce     <= 1'b1;
                  byte_valid <= 1'b0;
                  counter    <= counter - 1'b1;
                  if (counter == '0) begin
                     state <= st_store_conf;
                     if (rom_copy)
                        ddr3_addr <= save_addr;    // Back to the records
                  end
               end
            end
            st_store_conf: begin
               sdram_rq <= 1'b0;
               rom_copy <= 1'b0;
               state    <= st_read_conf;
               case (conf_typ)
                  config_config: begin
                     bios_config.slot_expander_en <= conf[5][3:0];
                     bios_config.MSX_typ          <= MSX_typ_t'(conf[5][5:4]);
                  end
                  config_kbd_layout: ddr3_addr <= ddr3_addr + 28'h200;  // Skip layout data
                  config_none, config_slot_a, config_slot_b, config_fdc:
                     ref_ram <= ref_ram + 1'b1;
                  default: state <= st_idle;
               endcase
            end
            default: state <= st_idle;
         endcase

         // A new download restarts the whole upload
         if (load) begin
            state      <= st_clean;
            ddr3_rd    <= 1'b0;
            ddr3_addr  <= '0;
            ram_addr   <= '0;
            ram_ce     <= 1'b0;
            sdram_rq   <= 1'b0;
            ref_ram    <= '0;
            head       <= '0;
            byte_valid <= 1'b0;
            rom_copy   <= 1'b0;
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset) ram_ce |=> !ram_ce);

   // DDR3 address holds until the read is served
   assert property (@(posedge clk) disable iff (reset)
      ddr3_rd && !ddr3_ready && !load |=> $stable(ddr3_addr));

endmodule

// ==== memory_upload_tests.txt ====
// op 01 DDR3 pointer, 02 sixteen DDR3 bytes, 03 download index/size, 04 eject, 00 end
// op 05 writes/sum/pattern lo/hi, 06 slot/block, 07 lookup idx/addr/size/ro, 08 bios
01_00000000_00000000_00000000_00000000
02_4d535900_00000000_00000000_00000000
05_00000000_00000000_00000000_00000000
03_00000000_00000000_00000001_00000010
01_00000000_00000000_00000000_00000000
02_4d535800_011a0000_00000000_00000000
02_4d535881_04000183_02c40100_00000000
02_4d535802_0000004a_03000000_00000000
05_00004000_001fe000_00000000_00004000
06_00000000_00000000_00000000_00030442
06_00000000_00000000_00000000_00040441
06_00000000_00000000_00000000_000a0802
07_00000000_00000000_00000000_00010000
08_00000000_00000000_00000000_00000029
03_00000000_00000000_00000001_00000030
01_00000000_00000000_00000000_00000030
02_4d535806_020000a0_00a10100_00000000
05_00004000_001fe000_00000000_00004000
06_00000000_00000000_00000000_00030442
06_00000000_00000000_00000000_00040441
06_00000000_00000000_00000000_000a0802
03_00000000_00000000_00000001_00000040
01_00000000_00000000_00000000_00a00000
02_32006032_ff770000_00000000_00000000
05_00018000_001fe23a_00000000_00004000
06_00000000_00000000_00000000_00030442
06_00000000_00000000_00000000_00040441
06_00000000_00000000_00000000_000a0802
06_00000000_00000000_00000000_00201408
06_00000000_00000000_00000000_00211409
07_02000000_00000000_00004000_00050001
03_00000000_00000000_00000003_00014000
05_00004000_001fe000_00000000_00004000
06_00000000_00000000_00000000_00030442
06_00000000_00000000_00000000_00040441
06_00000000_00000000_00000000_000a0802
04_00000000_00000000_00000000_00000000
00_00000000_00000000_00000000_00000000

// ==== msx_memory_upload.sv ====
`timescale 1ns/1ns
`include "upload_consts.svh"

module msx_memory_upload
   import msx_pkg::*, upload_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         ioctl_download,
   input  logic         rom_eject,
   input  logic  [15:0] ioctl_index,
   input  img_size_t    ioctl_addr,
   input  conf_byte_t   ddr3_dout,
   input  logic         ddr3_ready,
   input  logic         sdram_ready,
   output logic         reset_rq,
   output logic         ddr3_rd,
   output logic         ddr3_request,
   output logic         ram_ce,
   output logic         sdram_rq,
   output ddr_addr_t    ddr3_addr,
   output ram_addr_t    ram_addr,
   output conf_byte_t   ram_din,
   output lookup_RAM_t  lookup_RAM [`UPL_LOOKUPS],
   output bios_config_t bios_config,
   output block_t       slot_layout [`UPL_SLOTS]
);

   img_size_t   rom_size;
   logic        detect_restart;
   mapper_typ_t detected;

   slot_if slots ();

   memory_upload i_memory_upload (
      .clk            (clk),
      .reset          (reset),
      .ioctl_download (ioctl_download),
      .rom_eject      (rom_eject),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .ddr3_dout      (ddr3_dout),
      .ddr3_ready     (ddr3_ready),
      .sdram_ready    (sdram_ready),
      .reset_rq       (reset_rq),
      .ddr3_rd        (ddr3_rd),
      .ddr3_request   (ddr3_request),
      .ram_ce         (ram_ce),
      .sdram_rq       (sdram_rq),
      .detect_restart (detect_restart),
      .ddr3_addr      (ddr3_addr),
      .ram_addr       (ram_addr),
      .ram_din        (ram_din),
      .lookup_RAM     (lookup_RAM),
      .bios_config    (bios_config),
      .rom_size       (rom_size),
      .slots          (slots.seq)
   );

   // Watches the bytes as they go to SDRAM
   mapper_detect i_mapper_detect (
      .clk      (clk),
      .reset    (reset),
      .restart  (detect_restart),
      .sample   (ram_ce),
      .data     (ram_din),
      .rom_size (rom_size),
      .mapper   (detected)
   );

   slot_table i_slot_table (
      .clk         (clk),
      .reset       (reset),
      .slots       (slots.tbl),
      .detected    (detected),
      .slot_layout (slot_layout)
   );

endmodule

// ==== msx_pkg.sv ====
package msx_pkg;

   typedef enum logic [5:0] {
      mapper_unused,
      mapper_offset,
      mapper_konami,
      mapper_konami_scc,
      mapper_ascii8,
      mapper_ascii16,
      mapper_auto            // Resolved by the detector
   } mapper_typ_t;

   typedef enum logic [3:0] {
      device_none,
      device_fdc
   } device_typ_t;

   typedef enum logic [1:0] {
      msx1,
      msx2,
      msx2p,
      msx_tr
   } MSX_typ_t;

   // One entry of the slot layout
   typedef struct packed {
      mapper_typ_t mapper;
      device_typ_t device;
      logic  [3:0] ref_ram;      // Index into the lookup table
      logic  [1:0] offset_ram;
   } block_t;

   typedef struct packed {
      logic [26:0] addr;
      logic [15:0] size;         // 16 KiB pages
      logic        ro;
   } lookup_RAM_t;

   typedef struct packed {
      logic [3:0] slot_expander_en;
      MSX_typ_t   MSX_typ;
   } bios_config_t;

endpackage

// ==== slot_if.sv ====
`timescale 1ns/1ns

interface slot_if
   import msx_pkg::*, upload_pkg::*;
();

   logic         clear;       // Wipes every entry
   logic         store;
   logic   [3:0] ref_ram;
   mapper_typ_t  mapper;
   device_typ_t  device;
   slot_target_t target [4];

   // Sequencer side
   modport seq (
      output clear, store, ref_ram, mapper, device, target
   );

   // Table side
   modport tbl (
      input clear, store, ref_ram, mapper, device, target
   );

endinterface

// ==== slot_table.sv ====
`timescale 1ns/1ns
`include "upload_consts.svh"

module slot_table
   import msx_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   slot_if.tbl         slots,
   input  mapper_typ_t detected,
   output block_t      slot_layout [`UPL_SLOTS]
);

   mapper_typ_t mapper;

   assign mapper = slots.mapper == mapper_auto ? detected : slots.mapper;

   always_ff @(posedge clk) begin
      if (reset || slots.clear) begin
         for (int i = 0; i < `UPL_SLOTS; i++)
            slot_layout[i] <= '0;          // Unused, no device
      end else if (slots.store) begin
         for (int t = 0; t < 4; t++) begin
            if (slots.target[t].code != 2'd0) begin
               if (slots.target[t].code[1]) begin
                  slot_layout[slots.target[t].slot].ref_ram <= slots.ref_ram;
                  slot_layout[slots.target[t].slot].offset_ram <=
                     slots.target[t].offset[1:0];
               end else begin
                  // Alias reads the table as it was before this record
                  slot_layout[slots.target[t].slot].ref_ram <=
                     slot_layout[slots.target[t].offset].ref_ram;
                  slot_layout[slots.target[t].slot].offset_ram <=
                     slot_layout[slots.target[t].offset].offset_ram;
               end
               slot_layout[slots.target[t].slot].mapper <= mapper;
               slot_layout[slots.target[t].slot].device <= slots.device;
            end
         end
      end
   end

   // Clean phase and record stores never overlap
   assert property (@(posedge clk) disable iff (reset) !(slots.store && slots.clear));

endmodule

// ==== tb_msx_memory_upload.sv ====
`timescale 1ns/1ns
`include "upload_consts.svh"

module tb_msx_memory_upload
   import msx_pkg::*, upload_pkg::*;
();

   logic          clk;
   logic          reset;
   logic          ioctl_download;
   logic          rom_eject;
   logic   [15:0] ioctl_index;
   img_size_t     ioctl_addr;
   conf_byte_t    ddr3_dout;
   logic          ddr3_ready;
   logic          sdram_ready;
   logic          reset_rq;
   logic          ddr3_rd;
   logic          ddr3_request;
   logic          ram_ce;
   logic          sdram_rq;
   ddr_addr_t     ddr3_addr;
   ram_addr_t     ram_addr;
   conf_byte_t    ram_din;
   lookup_RAM_t   lookup_RAM [`UPL_LOOKUPS];
   bios_config_t  bios_config;
   block_t        slot_layout [`UPL_SLOTS];

   logic  [135:0] tests [256];     // Command in bits 135:128
   conf_byte_t    ddr_mem [int];
   conf_byte_t    sdram_mem [int];
   logic   [31:0] lfsr;
   int            cycles;
   int            cycle_limit;
   int            tb_errors;
   int            errors;
   int            checked;

   logic   [15:0] exp_slot [`UPL_SLOTS];
   lookup_RAM_t   exp_lookup [`UPL_LOOKUPS];
   logic    [5:0] exp_bios;
   logic   [31:0] exp_writes;
   logic   [31:0] exp_sum;
   logic   [31:0] pat_lo;
   logic   [31:0] pat_hi;

   msx_memory_upload i_msx_memory_upload (.*);

   upload_checker i_checker (.*);

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? (s >> 1) ^ 32'ha300_0000 : s >> 1;
   endfunction

   function automatic logic take_bit();
      take_bit = lfsr[0];
      lfsr     = lfsr_next(lfsr);
   endfunction

   function automatic conf_byte_t ddr_byte(input ddr_addr_t a);
      return ddr_mem.exists(int'(a)) ? ddr_mem[int'(a)] : 8'h00;
   endfunction

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Ready lines drop on about one cycle in eight
   always @(posedge clk) begin
      logic b0, b1, b2;
      #2;
      b0 = take_bit();
      b1 = take_bit();
      b2 = take_bit();
      ddr3_ready = !(b0 && b1 && b2);
      b0 = take_bit();
      b1 = take_bit();
      b2 = take_bit();
      sdram_ready = !(b0 && b1 && b2);
      ddr3_dout   = ddr_byte(ddr3_addr);
   end

   // Each upload writes every SDRAM address once
   always @(posedge clk) begin
      if (!reset_rq) begin
         sdram_mem.delete();
      end else if (ram_ce) begin
         if (sdram_mem.exists(int'(ram_addr))) begin
            tb_errors++;
            $display("SDRAM address %h written twice in one upload", ram_addr);
         end
         sdram_mem[int'(ram_addr)] = ram_din;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: uploads still running after %0d cycles", cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic wait_upload();
      do @(posedge clk); while (!reset_rq);
      do @(posedge clk); while (reset_rq);
      @(posedge clk);
      #2;
   endtask

   task automatic run_download(input logic [15:0] index, input img_size_t size);
      ioctl_index    = index;
      ioctl_addr     = size;
      ioctl_download = 1'b1;
      repeat (3) @(posedge clk);
      #2 ioctl_download = 1'b0;
      wait_upload();
   endtask

   task automatic run_eject();
      rom_eject = 1'b1;
      @(posedge clk);
      #2 rom_eject = 1'b0;
      wait_upload();
   endtask

   initial begin
      logic [135:0] cmd;
      int           ptr;
      int           n_tests;
      int           total;
      reset          = 1'b1;
      ioctl_download = 1'b0;
      rom_eject      = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      ddr3_dout      = '0;
      ddr3_ready     = 1'b0;
      sdram_ready    = 1'b0;
      lfsr           = 32'hff35_ff80;
      cycles         = 0;
      cycle_limit    = 0;
      tb_errors      = 0;
      exp_bios       = '0;
      exp_writes     = '0;
      exp_sum        = '0;
      pat_lo         = '0;
      pat_hi         = '0;
      for (int s = 0; s < `UPL_SLOTS; s++)
         exp_slot[s] = '0;
      for (int l = 0; l < `UPL_LOOKUPS; l++)
         exp_lookup[l] = '0;
      for (int i = 0; i < 256; i++)
         tests[i] = '0;
      $readmemh("memory_upload_tests.txt", tests);

      total   = 0;
      n_tests = 0;
      for (int i = 0; i < 256; i++) begin
         case (tests[i][135:128])
            8'h02:        total += 16;
            8'h03, 8'h04: n_tests++;
            8'h05:        total += int'(tests[i][127:96]);
            default: ;
         endcase
      end
      cycle_limit = 4 * total + 200 * n_tests;

      repeat (4) @(posedge clk);
      #2 reset = 1'b0;

      ptr = 0;
      for (int i = 0; i < 256 && tests[i][135:128] != 8'h00; i++) begin
         cmd = tests[i];
         case (cmd[135:128])
            8'h01: ptr = int'(cmd[27:0]);
            8'h02: begin
               for (int b = 0; b < 16; b++) begin
                  ddr_mem[ptr] = cmd[127 - 8 * b -: 8];
                  ptr++;
               end
            end
            8'h03: run_download(cmd[47:32], cmd[26:0]);
            8'h04: run_eject();
            8'h05: begin
               for (int s = 0; s < `UPL_SLOTS; s++)
                  exp_slot[s] = '0;         // Clean phase wipes every slot
               exp_writes = cmd[127:96];
               exp_sum    = cmd[95:64];
               pat_lo     = cmd[63:32];
               pat_hi     = cmd[31:0];
            end
            8'h06: exp_slot[cmd[21:16]] = cmd[15:0];
            8'h07: exp_lookup[cmd[123:120]] = '{addr: cmd[58:32], size: cmd[31:16], ro: cmd[0]};
            8'h08: exp_bios = cmd[5:0];
            default: begin
               tb_errors++;
               $display("Unknown command %h on tests line %0d", cmd[135:128], i);
            end
         endcase
      end

      $display("Uploads checked: %0d of %0d, errors: %0d", checked, n_tests,
               errors + tb_errors);
      if (errors == 0 && tb_errors == 0 && checked == n_tests)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== upload_checker.sv ====
`timescale 1ns/1ns
`include "upload_consts.svh"

module upload_checker
   import msx_pkg::*, upload_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         reset_rq,
   input  logic         ddr3_rd,
   input  logic         ddr3_request,
   input  logic         ram_ce,
   input  logic         sdram_rq,
   input  logic         sdram_ready,
   input  ram_addr_t    ram_addr,
   input  conf_byte_t   ram_din,
   input  block_t       slot_layout [`UPL_SLOTS],
   input  lookup_RAM_t  lookup_RAM [`UPL_LOOKUPS],
   input  bios_config_t bios_config,
   input  logic  [15:0] exp_slot [`UPL_SLOTS],
   input  lookup_RAM_t  exp_lookup [`UPL_LOOKUPS],
   input  logic   [5:0] exp_bios,
   input  logic  [31:0] exp_writes,
   input  logic  [31:0] exp_sum,
   input  logic  [31:0] pat_lo,
   input  logic  [31:0] pat_hi,
   output int           errors,
   output int           checked
);

   logic        rq_q;
   logic        ready_q;
   logic [31:0] writes;
   logic [31:0] sum;

   // Power-on RAM pattern, FFh where address bits 8 and 1 agree
   function automatic conf_byte_t pattern_byte(input ram_addr_t a);
      return (a[8] == a[1]) ? 8'hff : 8'h00;
   endfunction

   task automatic compare_tables();
      for (int s = 0; s < `UPL_SLOTS; s++) begin
         if (16'(slot_layout[s]) !== exp_slot[s]) begin
            errors++;
            $display("** Error at %0t: slot %0d is %h, expected %h",
                     $time, s, 16'(slot_layout[s]), exp_slot[s]);
         end
      end
      for (int l = 0; l < `UPL_LOOKUPS; l++) begin
         if (lookup_RAM[l] !== exp_lookup[l]) begin
            errors++;
            $display("** Error at %0t: lookup %0d is %h, expected %h",
                     $time, l, lookup_RAM[l], exp_lookup[l]);
         end
      end
      if (6'(bios_config) !== exp_bios) begin
         errors++;
         $display("** Error at %0t: bios_config is %h, expected %h",
                  $time, 6'(bios_config), exp_bios);
      end
      if (writes !== exp_writes || sum !== exp_sum) begin
         errors++;
         $display("** Error at %0t: %0d SDRAM writes with sum %h, expected %0d with sum %h",
                  $time, writes, sum, exp_writes, exp_sum);
      end
      checked++;
   endtask

   always @(posedge clk) begin
      if (reset) begin
         rq_q    = 1'b0;
         ready_q = 1'b0;
         writes  = '0;
         sum     = '0;
         errors  = 0;
         checked = 0;
      end else begin
         if (reset_rq && !rq_q) begin
            writes = '0;
            sum    = '0;
         end
         if (ram_ce) begin
            if (!ready_q) begin
               errors++;
               $display("** Error at %0t: ram_ce issued while sdram_ready was low", $time);
            end
            if (!sdram_rq) begin
               errors++;
               $display("** Error at %0t: ram_ce issued without sdram_rq", $time);
            end
            writes = writes + 1;
            sum    = sum + ram_din;
            if (ram_addr >= pat_lo && ram_addr < pat_hi &&
                ram_din !== pattern_byte(ram_addr)) begin
               errors++;
               $display("** Error at %0t: SDRAM byte at %h is %h, expected %h",
                        $time, ram_addr, ram_din, pattern_byte(ram_addr));
            end
         end
         if (ddr3_rd && !ddr3_request) begin
            errors++;
            $display("** Error at %0t: ddr3_rd issued without ddr3_request", $time);
         end
         // Bus requests end with the upload
         if (!reset_rq && !rq_q && (ddr3_request || ddr3_rd || sdram_rq)) begin
            errors++;
            $display("** Error at %0t: memory requests still active outside an upload",
                     $time);
         end
         if (!reset_rq && rq_q)
            compare_tables();        // End of an upload
         rq_q    = reset_rq;
         ready_q = sdram_ready;
      end
   end

endmodule

// ==== upload_consts.svh ====
`ifndef UPLOAD_CONSTS_SVH
`define UPLOAD_CONSTS_SVH

// Record layout
`define UPL_CONF_BYTES 16

// Table sizes
`define UPL_SLOTS   64
`define UPL_LOOKUPS 16

`define UPL_ROM_A_BASE 28'hA00000   // ROM A image in the DDR3 buffer

`define UPL_PAGE_BITS 14

// Smaller ROMs run without a mapper
`define UPL_DETECT_MIN 27'h10000

`endif

// ==== upload_pkg.sv ====
package upload_pkg;

   // Record kind, byte 4 of a record
   typedef enum logic [7:0] {
      config_none,
      config_config,
      config_slot_a,
      config_slot_b,
      config_fdc,
      config_kbd_layout
   } config_typ_t;

   typedef logic [27:0] ddr_addr_t;
   typedef logic [26:0] ram_addr_t;
   typedef logic [26:0] img_size_t;
   typedef logic  [7:0] conf_byte_t;

   // Two record bytes per target
   typedef struct packed {
      logic [1:0] code;          // 0 skip, 1 alias, 2 or 3 direct
      logic [5:0] slot;
      logic [5:0] offset;        // Source slot for an alias
   } slot_target_t;

endpackage
